// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+include
logic/uart_pkg.sv
logic/uart_fifo_if.sv
logic/uart_fifo.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
tb/tb_uart.sv

// ==== include/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// entries per FIFO, must be a power of two
`define UART_FIFO_DEPTH 16

// divisor latch after reset, kept small for short simulations
`define UART_RESET_DIVISOR 16'd2

// registers are byte-indexed 0 to 7
`define UART_ADDR_W 3

`endif

// ==== logic/uart_baud_gen.sv ====
`timescale 1ns/1ns

module uart_baud_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] divisor,
    output logic        tick
);
    logic [15:0] cnt;

    // reload on wrap, so a divisor change lands at the next period
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == '0) begin
            cnt <= divisor - 16'd1;
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

    assign tick = (cnt == '0);

    divisor_nonzero: assert property (@(posedge clk) disable iff (rst) divisor != '0);

endmodule

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ns

module uart_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 16
) (
    input logic       clk,
    input logic       rst,
    uart_fifo_if.fifo bus
);
    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    // extra msb tells full from empty when the addresses match
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] count;
    logic        do_push;
    logic        do_pop;

    assign bus.empty = (wr_ptr == rd_ptr);
    assign bus.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = bus.push && !bus.full;
    assign do_pop  = bus.pop && !bus.empty;
    assign count   = wr_ptr - rd_ptr;

    // first-word fall-through
    assign bus.pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst || bus.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= bus.push_data;
        end
    end

    // occupancy never goes past the depth
    occupancy_bound: assert property (@(posedge clk) disable iff (rst)
        count[AW] |-> (count[AW-1:0] == '0));

endmodule

// ==== logic/uart_fifo_if.sv ====
`timescale 1ns/1ns

interface uart_fifo_if #(
    parameter type T = logic [7:0]
);
    logic push;
    T     push_data;
    logic full;
    logic pop;
    T     pop_data;
    logic empty;
    logic flush;

    // flush is driven by whichever side is the register block
    modport producer (
        output push, push_data, flush,
        input  full, empty
    );

    modport consumer (
        output pop, flush,
        input  pop_data, empty
    );

    modport fifo (
        input  push, push_data, pop, flush,
        output full, pop_data, empty
    );
endinterface

// ==== logic/uart_pkg.sv ====
package uart_pkg;

    // register map, DLAB selects DLL/DLM on the first two addresses
    typedef enum logic [2:0] {
        RBR_THR_DLL = 3'd0,
        IER_DLM     = 3'd1,
        IIR_FCR     = 3'd2,
        LCR         = 3'd3,
        MCR         = 3'd4,
        LSR         = 3'd5,
        MSR         = 3'd6,
        SPR         = 3'd7
    } uart_reg_e;

    typedef logic [7:0] byte_t;

    // rx FIFO entry, fe marks a low stop bit
    typedef struct packed {
        logic  fe;
        byte_t data;
    } rx_char_t;

    // line status register bit positions
    localparam int LSR_DR   = 0;
    localparam int LSR_OE   = 1;
    localparam int LSR_FE   = 3;
    localparam int LSR_THRE = 5;
    localparam int LSR_TEMT = 6;

endpackage

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ns

`include "uart_macros.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`UART_ADDR_W-1:0] paddr,
    input  logic [7:0]              pwdata,
    output logic [7:0]              prdata,
    output logic                    pready,
    uart_fifo_if.producer           tx_fifo,
    uart_fifo_if.consumer           rx_fifo,
    input  logic                    tx_busy,
    input  logic                    overrun,
    output logic [15:0]             divisor,
    output logic                    loop,
    output logic                    irq
);
    uart_reg_e  addr;
    logic       wr;
    logic       rd;
    logic       dlab;
    logic [7:0] ier;
    logic [7:0] lcr;
    logic [7:0] mcr;
    logic [7:0] spr;
    logic [7:0] dll;
    logic [7:0] dlm;
    logic       oe;
    logic       fe;
    logic [7:0] lsr;
    logic [7:0] iir;
    logic       rx_int;
    logic       thr_int;

    assign addr   = uart_reg_e'(paddr);
    assign wr     = psel && penable && pwrite;
    assign rd     = psel && penable && !pwrite;
    assign dlab   = lcr[7];
    assign pready = 1'b1;

    assign tx_fifo.push      = wr && addr == RBR_THR_DLL && !dlab;
    assign tx_fifo.push_data = pwdata;
    assign rx_fifo.pop       = rd && addr == RBR_THR_DLL && !dlab;

    // FCR is write-only, its reset bits act as one-cycle flushes
    assign rx_fifo.flush = wr && addr == IIR_FCR && pwdata[1];
    assign tx_fifo.flush = wr && addr == IIR_FCR && pwdata[2];

    assign divisor = {dlm, dll};
    assign loop    = mcr[4];

    always_ff @(posedge clk) begin
        if (rst) begin
            ier <= '0;
            lcr <= 8'h03;
            mcr <= '0;
            spr <= '0;
            dll <= 8'(`UART_RESET_DIVISOR);
            dlm <= 8'(`UART_RESET_DIVISOR >> 8);
        end else if (wr) begin
            case (addr)
                RBR_THR_DLL: if (dlab) dll <= pwdata;
                IER_DLM: if (dlab) dlm <= pwdata; else ier <= pwdata;
                LCR: lcr <= pwdata;
                MCR: mcr <= pwdata;
                SPR: spr <= pwdata;
                default: ;
            endcase
        end
    end

    // sticky errors, a new event in the same cycle as the LSR read wins
    always_ff @(posedge clk) begin
        if (rst) begin
            oe <= 1'b0;
            fe <= 1'b0;
        end else begin
            if (overrun) begin
                oe <= 1'b1;
            end else if (rd && addr == LSR) begin
                oe <= 1'b0;
            end
            if (rx_fifo.pop && !rx_fifo.empty && rx_fifo.pop_data.fe) begin
                fe <= 1'b1;
            end else if (rd && addr == LSR) begin
                fe <= 1'b0;
            end
        end
    end

    always_comb begin
        lsr           = '0;
        lsr[LSR_DR]   = !rx_fifo.empty;
        lsr[LSR_OE]   = oe;
        lsr[LSR_FE]   = fe;
        lsr[LSR_THRE] = tx_fifo.empty;
        lsr[LSR_TEMT] = tx_fifo.empty && !tx_busy;
    end

    // received data outranks THR empty
    assign rx_int  = ier[0] && lsr[LSR_DR];
    assign thr_int = ier[1] && lsr[LSR_THRE];
    assign iir     = rx_int ? 8'h04 : thr_int ? 8'h02 : 8'h01;
    assign irq     = rx_int || thr_int;

    always_comb begin
        case (addr)
            RBR_THR_DLL: prdata = dlab ? dll : rx_fifo.pop_data.data;
            IER_DLM:     prdata = dlab ? dlm : ier;
            IIR_FCR:     prdata = iir;
            LCR:         prdata = lcr;
            MCR:         prdata = mcr;
            LSR:         prdata = lsr;
            MSR:         prdata = 8'hb0;
            default:     prdata = spr;
        endcase
    end

    // zero wait states, every setup cycle is followed by a completed access
    apb_access: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> (psel && penable && pready));

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
    import uart_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          tick,
    input  logic          rxd,
    input  logic          loop,
    input  logic          loop_txd,
    uart_fifo_if.producer fifo,
    output logic          overrun
);
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e  state;
    logic       rxd_s1;
    logic       rxd_s2;
    logic       line;
    logic       line_d;
    logic [3:0] tick_cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;
    logic       bit_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            line_d <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
            line_d <= line;
        end
    end

    assign line    = loop ? loop_txd : rxd_s2;
    assign bit_end = tick && (tick_cnt == 4'd15);

    // character is complete in the middle of the stop bit
    assign fifo.push      = (state == RX_STOP) && bit_end;
    assign fifo.push_data = '{fe: !line, data: shreg};
    assign overrun        = fifo.push && fifo.full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state == RX_IDLE) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= tick_cnt + 4'd1;
            end
            case (state)
                // falling edge, so a low stop bit does not restart the receiver
                RX_IDLE: if (line_d && !line) state <= RX_START;
                RX_START: if (tick && tick_cnt == 4'd7) begin
                    // half a bit in, the start bit must still be low
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= line ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {line, shreg[7:1]};
        end
    end

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/1ns

`include "uart_macros.svh"

module uart_top
    import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`UART_ADDR_W-1:0] paddr,
    input  logic [7:0]              pwdata,
    output logic [7:0]              prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    rx,
    output logic                    tx,
    output logic                    irq
);
    logic [15:0] divisor;
    logic        tick;
    logic        loop;
    logic        tx_busy;
    logic        overrun;

    uart_fifo_if #(.T(byte_t))    tx_fifo_bus ();
    uart_fifo_if #(.T(rx_char_t)) rx_fifo_bus ();

    assign pslverr = 1'b0;

    uart_regs uart_regs_inst (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .tx_fifo (tx_fifo_bus.producer),
        .rx_fifo (rx_fifo_bus.consumer),
        .tx_busy, .overrun, .divisor, .loop, .irq
    );

    uart_baud_gen uart_baud_gen_inst (.clk, .rst, .divisor, .tick);

    uart_fifo #(.T(byte_t), .DEPTH(`UART_FIFO_DEPTH)) tx_fifo_inst (
        .clk, .rst, .bus(tx_fifo_bus.fifo)
    );

    uart_fifo #(.T(rx_char_t), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo_inst (
        .clk, .rst, .bus(rx_fifo_bus.fifo)
    );

    uart_tx uart_tx_inst (
        .clk, .rst, .tick, .fifo(tx_fifo_bus.consumer), .txd(tx), .busy(tx_busy)
    );

    // loopback taps the registered tx line
    uart_rx uart_rx_inst (
        .clk, .rst, .tick, .rxd(rx), .loop, .loop_txd(tx),
        .fifo(rx_fifo_bus.producer), .overrun
    );

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx
    import uart_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          tick,
    uart_fifo_if.consumer fifo,
    output logic          txd,
    output logic          busy
);
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;

    // only start on a tick so every bit spans exactly 16 ticks
    assign fifo.pop = (state == TX_IDLE) && tick && !fifo.empty;
    assign busy     = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;
        end else begin
            if (state == TX_IDLE) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= tick_cnt + 4'd1;
            end
            case (state)
                TX_IDLE: if (fifo.pop) state <= TX_START;
                TX_START: if (tick && tick_cnt == 4'd15) begin
                    state   <= TX_DATA;
                    bit_idx <= '0;
                end
                TX_DATA: if (tick && tick_cnt == 4'd15) begin
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= TX_STOP;
                end
                TX_STOP: if (tick && tick_cnt == 4'd15) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
            txd <= (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shreg[0] : 1'b1;
        end
    end

    // lsb first, shift after each data bit
    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            shreg <= fifo.pop_data;
        end else if (state == TX_DATA && tick && tick_cnt == 4'd15) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

// ==== tb/tb_uart.sv ====
`timescale 1ns/1ns

`include "uart_macros.svh"

module tb_uart;

    // generous bound on LSR polling, in frames at the current divisor
    localparam int WAIT_FRAMES = 32;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`UART_ADDR_W-1:0] paddr;
    logic [7:0]              pwdata;
    logic [7:0]              prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    rx;
    logic                    tx;
    logic                    irq;

    // golden steps
    int    step_test[$];
    string step_op[$];
    int    step_addr[$];
    int    step_data[$];
    int    step_expect[$];

    // register state as the host sees it, for bit timing
    logic        cur_dlab;
    logic [15:0] cur_divisor;
    logic [15:0] max_divisor;
    int          frame_count;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    uart_top uart_top_inst (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .rx, .tx, .irq
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void track_config(input int addr, input int data);
        if (addr == 3) begin
            cur_dlab = data[7];
        end else if (cur_dlab && addr == 0) begin
            cur_divisor[7:0] = data[7:0];
        end else if (cur_dlab && addr == 1) begin
            cur_divisor[15:8] = data[7:0];
        end
        if (cur_divisor > max_divisor) begin
            max_divisor = cur_divisor;
        end
    endfunction

    task automatic load_golden();
        int    fd;
        string line;
        string op;
        int    t;
        int    a;
        int    d;
        int    e;
        fd = $fopen("tb/uart_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/uart_golden.txt");
            test_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if ($sscanf(line, "%d %s %h %h %h", t, op, a, d, e) == 5) begin
                    step_test.push_back(t);
                    step_op.push_back(op);
                    step_addr.push_back(a);
                    step_data.push_back(d);
                    step_expect.push_back(e);
                    // every THR write and every driven frame costs one frame time
                    if (op == "wr" && !cur_dlab && a == 0) begin
                        frame_count++;
                    end else if (op == "wrn") begin
                        frame_count += d;
                    end else if (op == "ser") begin
                        frame_count++;
                    end
                    if (op == "wr") begin
                        track_config(a, d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // zero wait states and no slave error on any access
    task automatic verify_response(input int addr);
        assert (pready === 1'b1 && pslverr === 1'b0) else begin
            $display("Mismatch at %0t: addr %0d pready %0b pslverr %0b during access",
                     $time, addr, pready, pslverr);
            test_errors++;
        end
    endtask

    task automatic apb_write(input int addr, input int data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr[`UART_ADDR_W-1:0];
        pwdata  <= data[7:0];
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        verify_response(addr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        track_config(addr, data);
    endtask

    task automatic apb_read(input int addr, output logic [7:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr[`UART_ADDR_W-1:0];
        @(posedge clk);
        penable <= 1'b1;
        // prdata is settled half way through the access cycle
        @(negedge clk);
        data = prdata;
        verify_response(addr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_value(input int addr, input logic [7:0] got, input int expected);
        assert (got == expected[7:0]) else begin
            $display("Mismatch at %0t: addr %0d expected %02h got %02h",
                     $time, addr, expected[7:0], got);
            test_errors++;
        end
    endtask

    task automatic check_pin(input int which, input int expected);
        logic level;
        @(negedge clk);
        level = (which == 0) ? tx : irq;
        assert (level == expected[0]) else begin
            $display("Mismatch at %0t: %s expected %0d got %0d",
                     $time, (which == 0) ? "tx" : "irq", expected[0], level);
            test_errors++;
        end
    endtask

    // 8N1 frame, LSB first, then one idle bit
    task automatic send_serial(input int data, input int stop);
        int         bit_cycles;
        logic [9:0] frame;
        bit_cycles = 16 * int'(cur_divisor);
        frame = {stop[0], data[7:0], 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (bit_cycles - 1) @(posedge clk);
    endtask

    // sticky bits cleared by an earlier poll still show in the OR of all polls
    task automatic wait_lsr_bit(input int addr, input int bit_pos, input int expected);
        logic [7:0] lsr;
        logic [7:0] seen;
        int         polls;
        int         max_polls;
        lsr = '0;
        seen = '0;
        polls = 0;
        max_polls = (WAIT_FRAMES * 10 * 16 * int'(cur_divisor)) / 3;
        while (!lsr[bit_pos] && polls < max_polls) begin
            apb_read(addr, lsr);
            seen = seen | lsr;
            polls++;
        end
        if (!lsr[bit_pos]) begin
            $display("timed out waiting for LSR bit %0d at %0t", bit_pos, $time);
            test_errors++;
        end else begin
            check_value(addr, seen, expected);
        end
    endtask

    task automatic finish_test(input int num);
        if (test_errors == 0) begin
            $display("test %0d passed", num);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        logic [7:0] value;
        int         limit;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rx = 1'b1;
        cur_dlab = 1'b0;
        cur_divisor = `UART_RESET_DIVISOR;
        max_divisor = `UART_RESET_DIVISOR;
        frame_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_golden();

        // twice the serial time of every frame at the slowest divisor
        limit = frame_count * 10 * 16 * int'(max_divisor) * 2 + 100;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("run did not finish within %0d cycles", limit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        join_none

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        cur_dlab = 1'b0;
        cur_divisor = `UART_RESET_DIVISOR;

        for (int idx = 0; idx < step_op.size(); idx++) begin
            if (step_op[idx] == "wr") begin
                apb_write(step_addr[idx], step_data[idx]);
            end else if (step_op[idx] == "rd") begin
                apb_read(step_addr[idx], value);
                check_value(step_addr[idx], value, step_expect[idx]);
            end else if (step_op[idx] == "wrn") begin
                for (int k = 0; k < step_data[idx]; k++) begin
                    apb_write(step_addr[idx], step_expect[idx] + k);
                end
            end else if (step_op[idx] == "rdn") begin
                for (int k = 0; k < step_data[idx]; k++) begin
                    apb_read(step_addr[idx], value);
                    check_value(step_addr[idx], value, step_expect[idx] + k);
                end
            end else if (step_op[idx] == "ser") begin
                send_serial(step_data[idx], step_expect[idx]);
            end else if (step_op[idx] == "wait") begin
                wait_lsr_bit(step_addr[idx], step_data[idx], step_expect[idx]);
            end else if (step_op[idx] == "pin") begin
                check_pin(step_addr[idx], step_expect[idx]);
            end else if (step_op[idx] == "end") begin
                finish_test(step_test[idx]);
            end else begin
                $display("unknown operation %s in golden file", step_op[idx]);
                test_errors++;
            end
        end
        if (test_errors != 0) begin
            tests_failed++;
        end

        $display("%0d tests: %0d passed, %0d failed",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb/uart_golden.txt ====
# columns: test op addr data expect, test in decimal, the rest in hex
# wrn/rdn: data is a count and expect the first byte, ser: expect is the stop bit level
# wait: data is the LSR bit, expect the OR of all LSR polls, pin: addr 0 is tx, 1 is irq
1 rd   3 00 03
1 rd   5 00 60
1 rd   2 00 01
1 pin  0 00 01
1 pin  1 00 00
1 wr   3 83 00
1 rd   0 00 02
1 rd   1 00 00
1 wr   3 03 00
1 end  0 00 00
2 wr   3 83 00
2 wr   0 03 00
2 wr   1 01 00
2 rd   0 00 03
2 rd   1 00 01
2 wr   3 03 00
2 wr   1 a0 00
2 wr   7 5a 00
2 rd   1 00 a0
2 rd   7 00 5a
2 rd   3 00 03
2 wr   3 83 00
2 rd   0 00 03
2 wr   0 02 00
2 wr   1 00 00
2 wr   3 03 00
2 wr   1 00 00
2 end  0 00 00
3 wr   4 10 00
3 wr   0 5a 00
3 wr   0 c3 00
3 wait 5 00 01
3 rd   0 00 5a
3 wait 5 00 21
3 rd   0 00 c3
3 end  0 00 00
4 wr   4 00 00
4 ser  0 a5 01
4 wait 5 00 61
4 rd   0 00 a5
4 rd   5 00 60
4 ser  0 3c 00
4 wait 5 00 61
4 rd   0 00 3c
4 rd   5 00 68
4 rd   5 00 60
4 end  0 00 00
5 wr   4 10 00
5 wrn  0 11 40
5 wait 5 06 63
5 rdn  0 10 40
5 rd   5 00 60
5 wrn  0 02 80
5 wait 5 06 61
5 wr   2 02 00
5 rd   5 00 60
5 end  0 00 00
6 pin  1 00 00
6 wr   1 01 00
6 pin  1 00 00
6 wr   0 77 00
6 wait 5 00 21
6 pin  1 00 01
6 rd   2 00 04
6 rd   0 00 77
6 wr   1 02 00
6 rd   2 00 02
6 pin  1 00 01
6 wr   1 00 00
6 pin  1 00 00
6 rd   2 00 01
6 end  0 00 00
